//--- common/axi_chan_pkg.sv
package axi_chan_pkg;

    // Address and data bus widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 16;

    // Burst length field carries the beat count minus one
    localparam int LEN_W = 4;

    // Encoded field widths of burst type and response code
    localparam int BURST_W = 2;
    localparam int RESP_W  = 2;

    // Burst type as carried on AW and AR
    typedef enum logic [BURST_W-1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axi_burst_e;

    // Response code as carried on B and R
    typedef enum logic [RESP_W-1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

endpackage

//--- common/id_remap_pkg.sv
package id_remap_pkg;

    // Transaction ID width seen by the managers
    localparam int ID_IN_W = 6;

    // Compact ID width handed to the subordinate
    localparam int ID_OUT_W = 2;

    // Outstanding transactions per direction
    localparam int TABLE_SIZE = 4;

    // Slot index width, equal to ID_OUT_W for a fully used ID space
    localparam int IDX_W = $clog2(TABLE_SIZE);

endpackage

//--- id_remap/id_remap_ctrl.sv
`timescale 1ns/100ps

module id_remap_ctrl (
    input  logic clk_i,
    input  logic rst_ni,

    // Write address and write response handshakes
    input  logic aw_valid_i,
    input  logic aw_ready_dn_i,
    input  logic b_valid_dn_i,
    input  logic b_ready_i,

    // Read address and read data handshakes
    input  logic ar_valid_i,
    input  logic ar_ready_dn_i,
    input  logic r_valid_dn_i,
    input  logic r_ready_i,
    input  logic r_last_dn_i,

    // Occupancy flags from the two remap tables
    input  logic aw_full_i,
    input  logic aw_empty_i,
    input  logic ar_full_i,
    input  logic ar_empty_i,

    output logic aw_ready_o,
    output logic aw_valid_dn_o,
    output logic b_valid_o,
    output logic b_ready_dn_o,
    output logic ar_ready_o,
    output logic ar_valid_dn_o,
    output logic r_valid_o,
    output logic r_ready_dn_o,

    // Table update strobes
    output logic aw_alloc_o,
    output logic b_release_o,
    output logic ar_alloc_o,
    output logic r_release_o
);

    logic aw_valid_gated;
    logic b_valid_gated;
    logic ar_valid_gated;
    logic r_valid_gated;

    // A full table holds off new requests on both sides
    assign aw_valid_gated = aw_valid_i & ~aw_full_i;
    assign ar_valid_gated = ar_valid_i & ~ar_full_i;

    assign aw_valid_dn_o = aw_valid_gated;
    assign aw_ready_o    = aw_ready_dn_i & ~aw_full_i;
    assign ar_valid_dn_o = ar_valid_gated;
    assign ar_ready_o    = ar_ready_dn_i & ~ar_full_i;

    // Responses are only meaningful while something is outstanding
    assign b_valid_gated = b_valid_dn_i & ~aw_empty_i;
    assign r_valid_gated = r_valid_dn_i & ~ar_empty_i;

    assign b_valid_o    = b_valid_gated;
    assign b_ready_dn_o = b_ready_i & ~aw_empty_i;
    assign r_valid_o    = r_valid_gated;
    assign r_ready_dn_o = r_ready_i & ~ar_empty_i;

    // Completed transfers turn into table updates
    assign aw_alloc_o  = aw_valid_gated & aw_ready_dn_i;
    assign ar_alloc_o  = ar_valid_gated & ar_ready_dn_i;
    assign b_release_o = b_valid_gated & b_ready_i;

    // A read slot stays busy until its final beat
    assign r_release_o = r_valid_gated & r_ready_i & r_last_dn_i;

endmodule

//--- id_remap/id_remap_table.sv
`timescale 1ns/100ps

module id_remap_table (
    input  logic                              clk_i,
    input  logic                              rst_ni,

    // Allocation side, driven by the request channel
    input  logic                              alloc_i,
    input  logic [id_remap_pkg::ID_IN_W-1:0]  id_i,
    output logic [id_remap_pkg::ID_OUT_W-1:0] id_o,
    output logic                              full_o,

    // Release side, driven by the response channel
    input  logic                              release_i,
    input  logic [id_remap_pkg::ID_OUT_W-1:0] rel_id_i,
    output logic [id_remap_pkg::ID_IN_W-1:0]  rel_id_o,
    output logic                              empty_o
);

    import id_remap_pkg::*;

    logic [TABLE_SIZE-1:0] valid_q;
    logic [ID_IN_W-1:0]    orig_id_q [TABLE_SIZE];
    logic [IDX_W-1:0]      free_idx;
    logic [IDX_W-1:0]      rel_idx;

    // Lowest free slot wins, scanning down so the last hit is the lowest
    always_comb begin
        free_idx = '0;
        for (int i = TABLE_SIZE - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_idx = IDX_W'(i);
            end
        end
    end

    assign full_o  = &valid_q;
    assign empty_o = ~|valid_q;

    // Downstream ID is the slot number itself
    assign id_o = free_idx;

    assign rel_idx  = rel_id_i;
    assign rel_id_o = orig_id_q[rel_idx];

    // Slot occupancy
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            if (alloc_i) begin
                valid_q[free_idx] <= 1'b1;
            end
            if (release_i) begin
                valid_q[rel_idx] <= 1'b0;
            end
        end
    end

    // Original IDs, only read back while the slot is busy
    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            orig_id_q[free_idx] <= id_i;
        end
    end

endmodule

//--- hdl/axi_id_remap_top.sv
`timescale 1ns/100ps

module axi_id_remap_top (
    input  logic                              clk_i,
    input  logic                              rst_ni,

    // Upstream write address
    input  logic                              aw_valid_i,
    output logic                              aw_ready_o,
    input  logic [id_remap_pkg::ID_IN_W-1:0]  aw_id_i,
    input  logic [axi_chan_pkg::ADDR_W-1:0]   aw_addr_i,
    input  logic [axi_chan_pkg::LEN_W-1:0]    aw_len_i,
    input  axi_chan_pkg::axi_burst_e          aw_burst_i,

    // Upstream write data
    input  logic                              w_valid_i,
    output logic                              w_ready_o,
    input  logic [axi_chan_pkg::DATA_W-1:0]   w_data_i,
    input  logic                              w_last_i,

    // Upstream write response
    output logic                              b_valid_o,
    input  logic                              b_ready_i,
    output logic [id_remap_pkg::ID_IN_W-1:0]  b_id_o,
    output axi_chan_pkg::axi_resp_e           b_resp_o,

    // Upstream read address
    input  logic                              ar_valid_i,
    output logic                              ar_ready_o,
    input  logic [id_remap_pkg::ID_IN_W-1:0]  ar_id_i,
    input  logic [axi_chan_pkg::ADDR_W-1:0]   ar_addr_i,
    input  logic [axi_chan_pkg::LEN_W-1:0]    ar_len_i,
    input  axi_chan_pkg::axi_burst_e          ar_burst_i,

    // Upstream read data
    output logic                              r_valid_o,
    input  logic                              r_ready_i,
    output logic [id_remap_pkg::ID_IN_W-1:0]  r_id_o,
    output logic [axi_chan_pkg::DATA_W-1:0]   r_data_o,
    output axi_chan_pkg::axi_resp_e           r_resp_o,
    output logic                              r_last_o,

    // Downstream write address
    output logic                              aw_valid_dn_o,
    input  logic                              aw_ready_dn_i,
    output logic [id_remap_pkg::ID_OUT_W-1:0] aw_id_dn_o,
    output logic [axi_chan_pkg::ADDR_W-1:0]   aw_addr_dn_o,
    output logic [axi_chan_pkg::LEN_W-1:0]    aw_len_dn_o,
    output axi_chan_pkg::axi_burst_e          aw_burst_dn_o,

    // Downstream write data
    output logic                              w_valid_dn_o,
    input  logic                              w_ready_dn_i,
    output logic [axi_chan_pkg::DATA_W-1:0]   w_data_dn_o,
    output logic                              w_last_dn_o,

    // Downstream write response
    input  logic                              b_valid_dn_i,
    output logic                              b_ready_dn_o,
    input  logic [id_remap_pkg::ID_OUT_W-1:0] b_id_dn_i,
    input  axi_chan_pkg::axi_resp_e           b_resp_dn_i,

    // Downstream read address
    output logic                              ar_valid_dn_o,
    input  logic                              ar_ready_dn_i,
    output logic [id_remap_pkg::ID_OUT_W-1:0] ar_id_dn_o,
    output logic [axi_chan_pkg::ADDR_W-1:0]   ar_addr_dn_o,
    output logic [axi_chan_pkg::LEN_W-1:0]    ar_len_dn_o,
    output axi_chan_pkg::axi_burst_e          ar_burst_dn_o,

    // Downstream read data
    input  logic                              r_valid_dn_i,
    output logic                              r_ready_dn_o,
    input  logic [id_remap_pkg::ID_OUT_W-1:0] r_id_dn_i,
    input  logic [axi_chan_pkg::DATA_W-1:0]   r_data_dn_i,
    input  axi_chan_pkg::axi_resp_e           r_resp_dn_i,
    input  logic                              r_last_dn_i
);

    import axi_chan_pkg::*;
    import id_remap_pkg::*;

    logic aw_full;
    logic aw_empty;
    logic ar_full;
    logic ar_empty;
    logic aw_alloc;
    logic b_release;
    logic ar_alloc;
    logic r_release;

    // Request payloads pass straight through
    assign aw_addr_dn_o  = aw_addr_i;
    assign aw_len_dn_o   = aw_len_i;
    assign aw_burst_dn_o = aw_burst_i;
    assign ar_addr_dn_o  = ar_addr_i;
    assign ar_len_dn_o   = ar_len_i;
    assign ar_burst_dn_o = ar_burst_i;

    // W carries no ID, so the whole channel is untouched
    assign w_valid_dn_o = w_valid_i;
    assign w_ready_o    = w_ready_dn_i;
    assign w_data_dn_o  = w_data_i;
    assign w_last_dn_o  = w_last_i;

    // Response payloads
    assign b_resp_o = b_resp_dn_i;
    assign r_data_o = r_data_dn_i;
    assign r_resp_o = r_resp_dn_i;
    assign r_last_o = r_last_dn_i;

    id_remap_ctrl u_ctrl (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .aw_valid_i    ( aw_valid_i    ),
        .aw_ready_dn_i ( aw_ready_dn_i ),
        .b_valid_dn_i  ( b_valid_dn_i  ),
        .b_ready_i     ( b_ready_i     ),
        .ar_valid_i    ( ar_valid_i    ),
        .ar_ready_dn_i ( ar_ready_dn_i ),
        .r_valid_dn_i  ( r_valid_dn_i  ),
        .r_ready_i     ( r_ready_i     ),
        .r_last_dn_i   ( r_last_dn_i   ),
        .aw_full_i     ( aw_full       ),
        .aw_empty_i    ( aw_empty      ),
        .ar_full_i     ( ar_full       ),
        .ar_empty_i    ( ar_empty      ),
        .aw_ready_o    ( aw_ready_o    ),
        .aw_valid_dn_o ( aw_valid_dn_o ),
        .b_valid_o     ( b_valid_o     ),
        .b_ready_dn_o  ( b_ready_dn_o  ),
        .ar_ready_o    ( ar_ready_o    ),
        .ar_valid_dn_o ( ar_valid_dn_o ),
        .r_valid_o     ( r_valid_o     ),
        .r_ready_dn_o  ( r_ready_dn_o  ),
        .aw_alloc_o    ( aw_alloc      ),
        .b_release_o   ( b_release     ),
        .ar_alloc_o    ( ar_alloc      ),
        .r_release_o   ( r_release     )
    );

    // Write direction, allocated on AW and freed on B
    id_remap_table u_aw_table (
        .clk_i     ( clk_i      ),
        .rst_ni    ( rst_ni     ),
        .alloc_i   ( aw_alloc   ),
        .id_i      ( aw_id_i    ),
        .id_o      ( aw_id_dn_o ),
        .full_o    ( aw_full    ),
        .release_i ( b_release  ),
        .rel_id_i  ( b_id_dn_i  ),
        .rel_id_o  ( b_id_o     ),
        .empty_o   ( aw_empty   )
    );

    // Read direction, allocated on AR and freed on the last R beat
    id_remap_table u_ar_table (
        .clk_i     ( clk_i      ),
        .rst_ni    ( rst_ni     ),
        .alloc_i   ( ar_alloc   ),
        .id_i      ( ar_id_i    ),
        .id_o      ( ar_id_dn_o ),
        .full_o    ( ar_full    ),
        .release_i ( r_release  ),
        .rel_id_i  ( r_id_dn_i  ),
        .rel_id_o  ( r_id_o     ),
        .empty_o   ( ar_empty   )
    );

endmodule

//--- bench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_no
);

    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 4;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Reset drops on a falling edge, clear of the sampling edge
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

//--- bench/tb_axi_id_remap.sv
`timescale 1ns/100ps

module tb_axi_id_remap;

    import axi_chan_pkg::*;
    import id_remap_pkg::*;

    localparam int NUM_TXN = 200;

    // Writes plus reads, each with a budget of 40 cycles
    localparam int TIMEOUT_CYCLES = 2 * NUM_TXN * 40;

    logic clk_i;
    logic rst_ni;

    // Upstream manager side
    logic                aw_valid_i;
    logic                aw_ready_o;
    logic [ID_IN_W-1:0]  aw_id_i;
    logic [ADDR_W-1:0]   aw_addr_i;
    logic [LEN_W-1:0]    aw_len_i;
    axi_burst_e          aw_burst_i;
    logic                w_valid_i;
    logic                w_ready_o;
    logic [DATA_W-1:0]   w_data_i;
    logic                w_last_i;
    logic                b_valid_o;
    logic                b_ready_i;
    logic [ID_IN_W-1:0]  b_id_o;
    axi_resp_e           b_resp_o;
    logic                ar_valid_i;
    logic                ar_ready_o;
    logic [ID_IN_W-1:0]  ar_id_i;
    logic [ADDR_W-1:0]   ar_addr_i;
    logic [LEN_W-1:0]    ar_len_i;
    axi_burst_e          ar_burst_i;
    logic                r_valid_o;
    logic                r_ready_i;
    logic [ID_IN_W-1:0]  r_id_o;
    logic [DATA_W-1:0]   r_data_o;
    axi_resp_e           r_resp_o;
    logic                r_last_o;

    // Downstream subordinate side
    logic                aw_valid_dn_o;
    logic                aw_ready_dn_i;
    logic [ID_OUT_W-1:0] aw_id_dn_o;
    logic [ADDR_W-1:0]   aw_addr_dn_o;
    logic [LEN_W-1:0]    aw_len_dn_o;
    axi_burst_e          aw_burst_dn_o;
    logic                w_valid_dn_o;
    logic                w_ready_dn_i;
    logic [DATA_W-1:0]   w_data_dn_o;
    logic                w_last_dn_o;
    logic                b_valid_dn_i;
    logic                b_ready_dn_o;
    logic [ID_OUT_W-1:0] b_id_dn_i;
    axi_resp_e           b_resp_dn_i;
    logic                ar_valid_dn_o;
    logic                ar_ready_dn_i;
    logic [ID_OUT_W-1:0] ar_id_dn_o;
    logic [ADDR_W-1:0]   ar_addr_dn_o;
    logic [LEN_W-1:0]    ar_len_dn_o;
    axi_burst_e          ar_burst_dn_o;
    logic                r_valid_dn_i;
    logic                r_ready_dn_o;
    logic [ID_OUT_W-1:0] r_id_dn_i;
    logic [DATA_W-1:0]   r_data_dn_i;
    axi_resp_e           r_resp_dn_i;
    logic                r_last_dn_i;

    // Reference model, downstream ID to upstream ID per direction
    bit [TABLE_SIZE-1:0] w_busy;
    bit [TABLE_SIZE-1:0] r_busy;
    logic [ID_IN_W-1:0]  w_map [TABLE_SIZE];
    logic [ID_IN_W-1:0]  r_map [TABLE_SIZE];

    // Subordinate model state
    logic [LEN_W-1:0]    r_len [TABLE_SIZE];
    int                  b_pend [$];
    int                  r_pend [$];
    int                  r_beats_left;
    bit                  r_in_burst;
    logic [DATA_W:0]     w_beats [$];

    // Transfers seen at the last sample, retired at the next falling edge
    bit                  aw_fire;
    bit                  w_fire;
    bit                  b_fire;
    bit                  ar_fire;
    bit                  r_fire;

    logic [31:0]         rng_state;
    int                  aw_sent;
    int                  ar_sent;
    int                  b_done;
    int                  r_done;
    int                  stall_w;
    int                  stall_r;
    int                  cycles;
    bit                  timed_out;
    int                  chk_cnt [1:6];
    int                  err_cnt [1:6];

    tb_clock_gen u_clock_gen (
        .clk_o  ( clk_i  ),
        .rst_no ( rst_ni )
    );

    axi_id_remap_top axi_id_remap_top_inst (.*);

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Slot the model expects for the next allocation
    function automatic int lowest_free(input bit [TABLE_SIZE-1:0] busy);
        int idx;
        idx = 0;
        while (idx < TABLE_SIZE && busy[idx]) begin
            idx++;
        end
        return idx;
    endfunction

    task automatic check_val(
        input int          beh,
        input string       name,
        input logic [31:0] got,
        input logic [31:0] exp
    );
        chk_cnt[beh]++;
        if (got !== exp) begin
            err_cnt[beh]++;
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_behavior(input int beh, input string what);
        $display("Behavior %0d, %s: %0d checks, %0d errors", beh, what, chk_cnt[beh],
                 err_cnt[beh]);
    endtask

    task automatic drive_cycle();
        int              k;
        logic [DATA_W:0] beat;
        // Write manager queues the W beats of each burst it issues
        if (aw_fire) begin
            aw_valid_i = 1'b0;
        end
        if (!aw_valid_i && aw_sent < NUM_TXN && next_rand() % 2 == 0) begin
            aw_valid_i = 1'b1;
            aw_id_i    = ID_IN_W'(next_rand());
            aw_addr_i  = ADDR_W'(next_rand());
            aw_len_i   = LEN_W'(next_rand());
            aw_burst_i = axi_burst_e'(BURST_W'(next_rand() % 3));
            aw_sent++;
            for (int i = 0; i <= aw_len_i; i++) begin
                w_beats.push_back({i == aw_len_i, DATA_W'(next_rand())});
            end
        end
        if (w_fire) begin
            w_valid_i = 1'b0;
        end
        if (!w_valid_i && w_beats.size() > 0 && next_rand() % 4 != 0) begin
            beat      = w_beats[0];
            w_valid_i = 1'b1;
            w_data_i  = beat[DATA_W-1:0];
            w_last_i  = beat[DATA_W];
        end
        if (ar_fire) begin
            ar_valid_i = 1'b0;
        end
        if (!ar_valid_i && ar_sent < NUM_TXN && next_rand() % 2 == 0) begin
            ar_valid_i = 1'b1;
            ar_id_i    = ID_IN_W'(next_rand());
            ar_addr_i  = ADDR_W'(next_rand());
            ar_len_i   = LEN_W'(next_rand());
            ar_burst_i = axi_burst_e'(BURST_W'(next_rand() % 3));
            ar_sent++;
        end
        aw_ready_dn_i = next_rand() % 4 != 0;
        w_ready_dn_i  = next_rand() % 4 != 0;
        ar_ready_dn_i = next_rand() % 4 != 0;
        b_ready_i     = next_rand() % 4 != 0;
        r_ready_i     = next_rand() % 4 != 0;

        // Subordinate answers outstanding IDs in random order
        if (b_fire) begin
            b_valid_dn_i = 1'b0;
        end
        if (!b_valid_dn_i && b_pend.size() > 0 && next_rand() % 8 == 0) begin
            k            = next_rand() % b_pend.size();
            b_id_dn_i    = ID_OUT_W'(b_pend[k]);
            b_resp_dn_i  = axi_resp_e'(RESP_W'(next_rand()));
            b_valid_dn_i = 1'b1;
            b_pend.delete(k);
        end
        if (r_fire) begin
            r_valid_dn_i = 1'b0;
            r_in_burst   = !r_last_dn_i;
        end
        if (!r_in_burst && r_pend.size() > 0 && next_rand() % 8 == 0) begin
            k            = next_rand() % r_pend.size();
            r_id_dn_i    = ID_OUT_W'(r_pend[k]);
            r_beats_left = r_len[r_pend[k]];
            r_in_burst   = 1'b1;
            r_pend.delete(k);
        end
        if (r_in_burst && !r_valid_dn_i) begin
            r_valid_dn_i = 1'b1;
            r_data_dn_i  = DATA_W'(next_rand());
            r_resp_dn_i  = axi_resp_e'(RESP_W'(next_rand()));
            r_last_dn_i  = r_beats_left == 0;
            r_beats_left--;
        end
    endtask

    task automatic sample_cycle();
        int                  slot;
        logic [DATA_W:0]     beat;
        bit [TABLE_SIZE-1:0] w_pre;
        bit [TABLE_SIZE-1:0] r_pre;
        // Table state as the DUT holds it before the coming edge
        w_pre   = w_busy;
        r_pre   = r_busy;
        aw_fire = aw_valid_i && !(&w_pre) && aw_ready_dn_i;
        ar_fire = ar_valid_i && !(&r_pre) && ar_ready_dn_i;
        w_fire  = w_valid_i && w_ready_dn_i;
        b_fire  = b_valid_dn_i && b_ready_i;
        r_fire  = r_valid_dn_i && r_ready_i;

        if (aw_valid_i && (&w_pre)) begin
            stall_w++;
            check_val(5, "aw_ready_o", aw_ready_o, 1'b0);
            check_val(5, "aw_valid_dn_o", aw_valid_dn_o, 1'b0);
        end else begin
            check_val(2, "aw_ready_o", aw_ready_o, aw_ready_dn_i && !(&w_pre));
            check_val(2, "aw_valid_dn_o", aw_valid_dn_o, aw_valid_i);
        end
        if (aw_fire) begin
            slot = lowest_free(w_pre);
            check_val(2, "aw_id_dn_o", aw_id_dn_o, slot);
            check_val(2, "aw_addr_dn_o", aw_addr_dn_o, aw_addr_i);
            check_val(2, "aw_len_dn_o", aw_len_dn_o, aw_len_i);
            check_val(2, "aw_burst_dn_o", aw_burst_dn_o, aw_burst_i);
            w_map[slot]  = aw_id_i;
            w_busy[slot] = 1'b1;
            b_pend.push_back(slot);
        end
        if (ar_valid_i && (&r_pre)) begin
            stall_r++;
            check_val(5, "ar_ready_o", ar_ready_o, 1'b0);
            check_val(5, "ar_valid_dn_o", ar_valid_dn_o, 1'b0);
        end else begin
            check_val(2, "ar_ready_o", ar_ready_o, ar_ready_dn_i && !(&r_pre));
            check_val(2, "ar_valid_dn_o", ar_valid_dn_o, ar_valid_i);
        end
        if (ar_fire) begin
            slot = lowest_free(r_pre);
            check_val(2, "ar_id_dn_o", ar_id_dn_o, slot);
            check_val(2, "ar_addr_dn_o", ar_addr_dn_o, ar_addr_i);
            check_val(2, "ar_len_dn_o", ar_len_dn_o, ar_len_i);
            check_val(2, "ar_burst_dn_o", ar_burst_dn_o, ar_burst_i);
            r_map[slot]  = ar_id_i;
            r_busy[slot] = 1'b1;
            r_len[slot]  = ar_len_i;
            r_pend.push_back(slot);
        end

        check_val(6, "w_valid_dn_o", w_valid_dn_o, w_valid_i);
        check_val(6, "w_ready_o", w_ready_o, w_ready_dn_i);
        if (w_fire) begin
            beat = w_beats.pop_front();
            check_val(6, "w_data_dn_o", w_data_dn_o, beat[DATA_W-1:0]);
            check_val(6, "w_last_dn_o", w_last_dn_o, beat[DATA_W]);
        end

        check_val(3, "b_valid_o", b_valid_o, b_valid_dn_i);
        check_val(3, "b_ready_dn_o", b_ready_dn_o, b_ready_i && (|w_pre));
        if (b_fire) begin
            check_val(3, "b_id_o", b_id_o, w_map[b_id_dn_i]);
            check_val(3, "b_resp_o", b_resp_o, b_resp_dn_i);
            w_busy[b_id_dn_i] = 1'b0;
            b_done++;
        end

        check_val(4, "r_valid_o", r_valid_o, r_valid_dn_i);
        check_val(4, "r_ready_dn_o", r_ready_dn_o, r_ready_i && (|r_pre));
        if (r_fire) begin
            check_val(4, "r_id_o", r_id_o, r_map[r_id_dn_i]);
            check_val(4, "r_data_o", r_data_o, r_data_dn_i);
            check_val(4, "r_resp_o", r_resp_o, r_resp_dn_i);
            check_val(4, "r_last_o", r_last_o, r_last_dn_i);
            // Only the last beat gives the slot back
            if (r_last_dn_i) begin
                r_busy[r_id_dn_i] = 1'b0;
                r_done++;
            end
        end
    endtask

    initial begin
        int total_chk;
        int total_err;
        rng_state     = 32'h3912716b;
        aw_valid_i    = 1'b0;
        aw_id_i       = '0;
        aw_addr_i     = '0;
        aw_len_i      = '0;
        aw_burst_i    = BURST_INCR;
        w_valid_i     = 1'b0;
        w_data_i      = '0;
        w_last_i      = 1'b0;
        ar_valid_i    = 1'b0;
        ar_id_i       = '0;
        ar_addr_i     = '0;
        ar_len_i      = '0;
        ar_burst_i    = BURST_INCR;
        aw_ready_dn_i = 1'b1;
        w_ready_dn_i  = 1'b0;
        ar_ready_dn_i = 1'b1;
        b_id_dn_i     = '0;
        b_resp_dn_i   = RESP_OKAY;
        r_id_dn_i     = '0;
        r_data_dn_i   = '0;
        r_resp_dn_i   = RESP_OKAY;

        // Spurious responses offered with empty tables must stay masked
        b_valid_dn_i  = 1'b1;
        b_ready_i     = 1'b1;
        r_valid_dn_i  = 1'b1;
        r_ready_i     = 1'b1;
        r_last_dn_i   = 1'b1;
        repeat (6) begin
            @(negedge clk_i);
            #1;
            check_val(1, "b_valid_o", b_valid_o, 1'b0);
            check_val(1, "r_valid_o", r_valid_o, 1'b0);
            check_val(1, "b_ready_dn_o", b_ready_dn_o, 1'b0);
            check_val(1, "r_ready_dn_o", r_ready_dn_o, 1'b0);
            check_val(1, "aw_ready_o", aw_ready_o, aw_ready_dn_i);
            check_val(1, "ar_ready_o", ar_ready_o, ar_ready_dn_i);
        end
        report_behavior(1, "handshakes idle after reset");
        @(negedge clk_i);
        b_valid_dn_i = 1'b0;
        r_valid_dn_i = 1'b0;
        r_last_dn_i  = 1'b0;

        while (!timed_out &&
               !(b_done == NUM_TXN && r_done == NUM_TXN && w_beats.size() == 0)) begin
            @(negedge clk_i);
            drive_cycle();
            #1;
            sample_cycle();
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                timed_out = 1'b1;
            end
        end

        if (timed_out) begin
            $display("Timeout after %0d cycles with %0d writes and %0d reads completed",
                     cycles, b_done, r_done);
        end
        if (stall_w == 0 || stall_r == 0) begin
            $display("A full remap table was never reached, so the stall went unexercised");
            err_cnt[5]++;
        end
        report_behavior(2, "request remap and pass-through");
        report_behavior(3, "write response ID restore");
        report_behavior(4, "read beat ID restore");
        report_behavior(5, "full table stall");
        report_behavior(6, "write data pass-through");
        total_chk = 0;
        total_err = 0;
        for (int i = 1; i <= 6; i++) begin
            total_chk += chk_cnt[i];
            total_err += err_cnt[i];
        end
        $display("Totals: %0d checks, %0d errors in %0d cycles", total_chk, total_err, cycles);
        if (total_err == 0 && !timed_out) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
common/axi_chan_pkg.sv
common/id_remap_pkg.sv
id_remap/id_remap_ctrl.sv
id_remap/id_remap_table.sv
hdl/axi_id_remap_top.sv
bench/tb_clock_gen.sv
bench/tb_axi_id_remap.sv

//--- Bender.yml
package:
  name: axi_id_remap

sources:
  # Shared packages first, then the remapper blocks and the top level
  - common/axi_chan_pkg.sv
  - common/id_remap_pkg.sv
  - id_remap/id_remap_ctrl.sv
  - id_remap/id_remap_table.sv
  - hdl/axi_id_remap_top.sv

  # Testbench, top module tb_axi_id_remap
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_axi_id_remap.sv
